//--- logic/readout_pkg.sv
`default_nettype none

package readout_pkg;

    localparam int BIN_WIDTH = 19;
    localparam int BCD_DIGITS = 6;
    localparam int CNT_WIDTH = $clog2(BIN_WIDTH);
    localparam logic [CNT_WIDTH-1:0] LAST_SHIFT = CNT_WIDTH'(BIN_WIDTH - 1);

    typedef logic [BIN_WIDTH-1:0] bin_t; // two's complement sample.
    typedef logic [BCD_DIGITS*4-1:0] bcd_t; // digit 0 sits in the low nibble.

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_SHIFT,
        CONV_ADD,
        CONV_DONE
    } conv_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_START,
        ARB_WAIT
    } arb_state_t;

    typedef enum logic [1:0] {
        CHAN_EMPTY,
        CHAN_REQUEST,
        CHAN_HOLD
    } chan_state_t;

endpackage

`default_nettype wire

//--- logic/display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int DIGIT_POSITIONS = 7;
    localparam int SCAN_TICKS = 4; // short so a full scan fits in a simulation.
    localparam int POS_WIDTH = $clog2(DIGIT_POSITIONS);
    localparam int TICK_WIDTH = $clog2(SCAN_TICKS);
    localparam logic [POS_WIDTH-1:0] SIGN_POS = POS_WIDTH'(DIGIT_POSITIONS - 1);
    localparam logic [TICK_WIDTH-1:0] LAST_TICK = TICK_WIDTH'(SCAN_TICKS - 1);

    typedef logic [6:0] seg_t; // bit 0 is segment a and bit 6 is segment g.
    typedef logic [DIGIT_POSITIONS-1:0] digit_sel_t; // one-hot, bit 6 is the sign.

    localparam seg_t SEG_TABLE [10] = '{
        7'h3f, // 0
        7'h06, // 1
        7'h5b, // 2
        7'h4f, // 3
        7'h66, // 4
        7'h6d, // 5
        7'h7d, // 6
        7'h07, // 7
        7'h7f, // 8
        7'h6f  // 9
    };

    localparam seg_t SEG_MINUS = 7'h40;
    localparam seg_t SEG_BLANK = 7'h00;

endpackage

`default_nettype wire

//--- logic/conv_if.sv
`timescale 1ns/1ps
`default_nettype none

interface conv_if;

    logic req; // level from a channel, a single-cycle start toward the converter.
    readout_pkg::bin_t value;
    readout_pkg::bcd_t bcd;
    logic negative;
    logic ready;

    modport client (
        output req,
        output value,
        input  bcd,
        input  negative,
        input  ready
    );

    modport server (
        input  req,
        input  value,
        output bcd,
        output negative,
        output ready
    );

endinterface

`default_nettype wire

//--- logic/bin_to_bcd.sv
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd (
    input  logic   clk,
    input  logic   reset,
    conv_if.server conv
);

    readout_pkg::conv_state_t state;
    readout_pkg::bin_t mag;
    readout_pkg::bcd_t bcd;
    logic negative;
    logic [readout_pkg::CNT_WIDTH-1:0] shift_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= readout_pkg::CONV_IDLE;
            shift_cnt <= '0;
        end else begin
            case (state)
                readout_pkg::CONV_IDLE: begin
                    shift_cnt <= '0;
                    if (conv.req) begin
                        state <= readout_pkg::CONV_SHIFT;
                    end
                end
                readout_pkg::CONV_SHIFT: begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == readout_pkg::LAST_SHIFT) begin
                        state <= readout_pkg::CONV_DONE; // no add after the last shift.
                    end else begin
                        state <= readout_pkg::CONV_ADD;
                    end
                end
                readout_pkg::CONV_ADD: begin
                    state <= readout_pkg::CONV_SHIFT;
                end
                readout_pkg::CONV_DONE: begin
                    state <= readout_pkg::CONV_IDLE;
                end
                default: begin
                    state <= readout_pkg::CONV_IDLE;
                end
            endcase
        end
    end

    // the magnitude of the most negative sample still fits as an unsigned value.
    always_ff @(posedge clk) begin
        if (state == readout_pkg::CONV_IDLE && conv.req) begin
            if (conv.value[readout_pkg::BIN_WIDTH-1]) begin
                mag <= ~conv.value + 1'b1;
            end else begin
                mag <= conv.value;
            end
        end else if (state == readout_pkg::CONV_SHIFT) begin
            mag <= {mag[readout_pkg::BIN_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bcd <= '0;
            negative <= 1'b0;
        end else begin
            case (state)
                readout_pkg::CONV_IDLE: begin
                    if (conv.req) begin
                        bcd <= '0;
                        negative <= conv.value[readout_pkg::BIN_WIDTH-1];
                    end
                end
                readout_pkg::CONV_SHIFT: begin
                    bcd <= {bcd[readout_pkg::BCD_DIGITS*4-2:0], mag[readout_pkg::BIN_WIDTH-1]};
                end
                readout_pkg::CONV_ADD: begin
                    for (int i = 0; i < readout_pkg::BCD_DIGITS; i++) begin
                        if (bcd[i*4 +: 4] > 4'd4) begin
                            bcd[i*4 +: 4] <= bcd[i*4 +: 4] + 4'd3;
                        end
                    end
                end
                default: begin
                    bcd <= bcd;
                end
            endcase
        end
    end

    assign conv.bcd = bcd;
    assign conv.negative = negative;
    assign conv.ready = (state == readout_pkg::CONV_DONE); // one cycle per conversion.

endmodule

`default_nettype wire

//--- logic/conv_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module conv_arbiter (
    input  logic   clk,
    input  logic   reset,
    conv_if.server chan_a,
    conv_if.server chan_b,
    conv_if.client conv
);

    readout_pkg::arb_state_t state;
    logic last_b; // owner during a conversion and last served afterwards.
    logic done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= readout_pkg::ARB_IDLE;
            last_b <= 1'b1; // channel a wins the first tie.
        end else begin
            case (state)
                readout_pkg::ARB_IDLE: begin
                    if (chan_a.req || chan_b.req) begin
                        state <= readout_pkg::ARB_START;
                        if (chan_a.req && chan_b.req) begin
                            last_b <= !last_b;
                        end else begin
                            last_b <= chan_b.req;
                        end
                    end
                end
                readout_pkg::ARB_START: begin
                    state <= readout_pkg::ARB_WAIT;
                end
                readout_pkg::ARB_WAIT: begin
                    if (conv.ready) begin
                        state <= readout_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= readout_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    assign conv.req = (state == readout_pkg::ARB_START);
    assign conv.value = last_b ? chan_b.value : chan_a.value;

    assign done = (state == readout_pkg::ARB_WAIT) && conv.ready;
    assign chan_a.ready = done && !last_b;
    assign chan_b.ready = done && last_b;

    // only the channel that sees ready takes the result.
    assign chan_a.bcd = conv.bcd;
    assign chan_a.negative = conv.negative;
    assign chan_b.bcd = conv.bcd;
    assign chan_b.negative = conv.negative;

endmodule

`default_nettype wire

//--- logic/readout_channel.sv
`timescale 1ns/1ps
`default_nettype none

module readout_channel (
    input  logic              clk,
    input  logic              reset,
    input  logic              sample,
    input  readout_pkg::bin_t value,
    conv_if.client            conv,
    output readout_pkg::bcd_t bcd,
    output logic              negative,
    output logic              update
);

    readout_pkg::chan_state_t state;
    readout_pkg::bin_t req_value;
    readout_pkg::bin_t pending_value;
    logic pending;
    logic load_req;
    logic stored;

    // a fresh strobe takes priority over the waiting sample.
    assign load_req = (state != readout_pkg::CHAN_REQUEST) && (sample || pending);
    assign stored = (state == readout_pkg::CHAN_REQUEST) && conv.ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= readout_pkg::CHAN_EMPTY;
            pending <= 1'b0;
        end else begin
            if (load_req) begin
                state <= readout_pkg::CHAN_REQUEST;
                pending <= 1'b0;
            end else if (state == readout_pkg::CHAN_REQUEST) begin
                if (sample) begin
                    pending <= 1'b1;
                end
                if (conv.ready) begin
                    state <= readout_pkg::CHAN_HOLD;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            req_value <= sample ? value : pending_value;
        end
        if (state == readout_pkg::CHAN_REQUEST && sample) begin
            pending_value <= value; // only the newest waiting sample is kept.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bcd <= '0;
            negative <= 1'b0;
            update <= 1'b0;
        end else begin
            update <= stored;
            if (stored) begin
                bcd <= conv.bcd;
                negative <= conv.negative;
            end
        end
    end

    assign conv.req = (state == readout_pkg::CHAN_REQUEST);
    assign conv.value = req_value;

endmodule

`default_nettype wire

//--- logic/segment_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module segment_scanner (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    display_sel,
    input  readout_pkg::bcd_t       bcd_a,
    input  readout_pkg::bcd_t       bcd_b,
    input  logic                    negative_a,
    input  logic                    negative_b,
    output display_pkg::seg_t       seg,
    output display_pkg::digit_sel_t digit_en
);

    logic [display_pkg::TICK_WIDTH-1:0] tick;
    logic [display_pkg::POS_WIDTH-1:0] pos;
    readout_pkg::bcd_t bcd_sel;
    logic negative_sel;
    logic [3:0] digit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick <= '0;
            pos <= '0;
        end else if (tick == display_pkg::LAST_TICK) begin
            tick <= '0;
            if (pos == display_pkg::SIGN_POS) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end else begin
            tick <= tick + 1'b1;
        end
    end

    assign bcd_sel = display_sel ? bcd_b : bcd_a;
    assign negative_sel = display_sel ? negative_b : negative_a;
    assign digit = 4'(bcd_sel >> (pos * 4)); // the sign position reads past the digits.

    always_comb begin
        if (pos == display_pkg::SIGN_POS) begin
            seg = negative_sel ? display_pkg::SEG_MINUS : display_pkg::SEG_BLANK;
        end else if (digit > 4'd9) begin
            seg = display_pkg::SEG_BLANK;
        end else begin
            seg = display_pkg::SEG_TABLE[digit];
        end
    end

    assign digit_en = display_pkg::digit_sel_t'(1) << pos;

endmodule

`default_nettype wire

//--- logic/readout_top.sv
`timescale 1ns/1ps
`default_nettype none

module readout_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_a,
    input  logic                    sample_b,
    input  readout_pkg::bin_t       value_a,
    input  readout_pkg::bin_t       value_b,
    input  logic                    display_sel,
    output readout_pkg::bcd_t       bcd_a,
    output readout_pkg::bcd_t       bcd_b,
    output logic                    negative_a,
    output logic                    negative_b,
    output logic                    update_a,
    output logic                    update_b,
    output display_pkg::seg_t       seg,
    output display_pkg::digit_sel_t digit_en
);

    conv_if chan_a_if ();
    conv_if chan_b_if ();
    conv_if conv_link_if (); // carries a start pulse instead of a level.

    readout_channel chan_a_i (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample_a),
        .value    (value_a),
        .conv     (chan_a_if),
        .bcd      (bcd_a),
        .negative (negative_a),
        .update   (update_a)
    );

    readout_channel chan_b_i (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample_b),
        .value    (value_b),
        .conv     (chan_b_if),
        .bcd      (bcd_b),
        .negative (negative_b),
        .update   (update_b)
    );

    conv_arbiter conv_arbiter_i (
        .clk    (clk),
        .reset  (reset),
        .chan_a (chan_a_if),
        .chan_b (chan_b_if),
        .conv   (conv_link_if)
    );

    bin_to_bcd bin_to_bcd_i (
        .clk   (clk),
        .reset (reset),
        .conv  (conv_link_if)
    );

    segment_scanner segment_scanner_i (
        .clk         (clk),
        .reset       (reset),
        .display_sel (display_sel),
        .bcd_a       (bcd_a),
        .bcd_b       (bcd_b),
        .negative_a  (negative_a),
        .negative_b  (negative_b),
        .seg         (seg),
        .digit_en    (digit_en)
    );

endmodule

`default_nettype wire

//--- dv/readout_tb.sv
`timescale 1ns/1ps
`default_nettype none

module readout_tb;

    localparam int NUM_DIRECTED = 8;
    localparam int NUM_ROWS = 20;
    localparam int SCAN_CYCLES = display_pkg::DIGIT_POSITIONS * display_pkg::SCAN_TICKS + 2;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 1) * 2 * 45 + NUM_ROWS * SCAN_CYCLES + 100;

    typedef struct packed {
        logic [1:0] mask; // bit 0 strobes channel a and bit 1 strobes channel b.
        readout_pkg::bin_t value_a;
        readout_pkg::bin_t value_b;
        logic display_sel;
        readout_pkg::bcd_t exp_bcd_a;
        logic exp_neg_a;
        readout_pkg::bcd_t exp_bcd_b;
        logic exp_neg_b;
    } row_t;

    logic clk;
    logic reset;
    logic sample_a;
    logic sample_b;
    readout_pkg::bin_t value_a;
    readout_pkg::bin_t value_b;
    logic display_sel;
    readout_pkg::bcd_t bcd_a;
    readout_pkg::bcd_t bcd_b;
    logic negative_a;
    logic negative_b;
    logic update_a;
    logic update_b;
    display_pkg::seg_t seg;
    display_pkg::digit_sel_t digit_en;

    row_t stim_rows [NUM_ROWS];
    int row_count = 0;
    readout_pkg::bcd_t run_bcd_a = '0; // held results expected after each row.
    readout_pkg::bcd_t run_bcd_b = '0;
    logic run_neg_a = 1'b0;
    logic run_neg_b = 1'b0;
    logic [18:0] lfsr_state;
    int upd_cnt_a = 0;
    int upd_cnt_b = 0;
    time upd_time_a = 0;
    time upd_time_b = 0;

    readout_top readout_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_bcd(input string what, input readout_pkg::bcd_t got_bcd,
                             input logic got_neg, input readout_pkg::bcd_t exp_bcd,
                             input logic exp_neg);
        if (got_bcd !== exp_bcd || got_neg !== exp_neg) begin
            $display("ERROR at %0t: %s shows bcd %h negative %b, expected bcd %h negative %b",
                     $time, what, got_bcd, got_neg, exp_bcd, exp_neg);
            stop_run();
        end
    endtask

    task automatic check_seg(input string what, input display_pkg::seg_t got_seg,
                             input display_pkg::digit_sel_t got_en,
                             input display_pkg::seg_t exp_seg,
                             input display_pkg::digit_sel_t exp_en);
        if (got_seg !== exp_seg || got_en !== exp_en) begin
            $display("ERROR at %0t: %s shows seg %h digit_en %b, expected seg %h digit_en %b",
                     $time, what, got_seg, got_en, exp_seg, exp_en);
            stop_run();
        end
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, want);
            stop_run();
        end
    endtask

    // decimal digits of the magnitude, computed by division.
    function automatic readout_pkg::bcd_t expected_bcd(input readout_pkg::bin_t v);
        int mag;
        readout_pkg::bcd_t digits;
        mag = v[readout_pkg::BIN_WIDTH-1] ? (1 << readout_pkg::BIN_WIDTH) - int'(v) : int'(v);
        digits = '0;
        for (int i = 0; i < readout_pkg::BCD_DIGITS; i++) begin
            digits[i*4 +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return digits;
    endfunction

    function automatic logic [18:0] lfsr_next(input logic [18:0] s);
        return {s[17:0], s[18] ^ s[17] ^ s[16] ^ s[13]}; // taps 19, 18, 17 and 14.
    endfunction

    task automatic draw_value(output readout_pkg::bin_t v);
        v = '0;
        for (int k = 0; k < readout_pkg::BIN_WIDTH; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[readout_pkg::BIN_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input logic [1:0] mask, input readout_pkg::bin_t a,
                           input readout_pkg::bin_t b, input logic sel);
        if (mask[0]) begin
            run_bcd_a = expected_bcd(a);
            run_neg_a = a[readout_pkg::BIN_WIDTH-1];
        end
        if (mask[1]) begin
            run_bcd_b = expected_bcd(b);
            run_neg_b = b[readout_pkg::BIN_WIDTH-1];
        end
        stim_rows[row_count] = '{mask, a, b, sel, run_bcd_a, run_neg_a, run_bcd_b, run_neg_b};
        row_count++;
    endtask

    task automatic build_table();
        readout_pkg::bin_t va;
        readout_pkg::bin_t vb;
        add_row(2'b01, 19'h00000, 19'h00000, 1'b0);
        add_row(2'b10, 19'h00000, 19'h00009, 1'b1);
        add_row(2'b01, 19'h0000a, 19'h00000, 1'b0);
        add_row(2'b10, 19'h00000, 19'h3ffff, 1'b1);
        add_row(2'b01, 19'h7ffff, 19'h00000, 1'b0);
        add_row(2'b10, 19'h00000, 19'h40000, 1'b1);
        add_row(2'b11, 19'h1e240, 19'h67e33, 1'b0); // 123456 and -98765.
        add_row(2'b11, 19'h7fe0c, 19'h0004d, 1'b1); // -500 and 77.
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            draw_value(va);
            draw_value(vb);
            add_row(2'(i % 3 + 1), va, vb, i[0]);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && update_a) begin
            upd_cnt_a = upd_cnt_a + 1;
            upd_time_a = $time;
        end
        if (!reset && update_b) begin
            upd_cnt_b = upd_cnt_b + 1;
            upd_time_b = $time;
        end
    end

    task automatic wait_updates(input int want_a, input int want_b);
        while (upd_cnt_a < want_a || upd_cnt_b < want_b) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // room for any stray extra update.
    endtask

    task automatic scan_display(input logic sel, input readout_pkg::bcd_t shown_bcd,
                                input logic shown_neg);
        display_pkg::digit_sel_t prev_en;
        display_pkg::digit_sel_t want_en;
        display_pkg::seg_t want_seg;
        int pos;
        int changes;
        @(negedge clk);
        prev_en = digit_en;
        pos = -1;
        for (int i = 0; i < display_pkg::DIGIT_POSITIONS; i++) begin
            if (prev_en == display_pkg::digit_sel_t'(1) << i) begin
                pos = i;
            end
        end
        if (pos < 0) begin
            $display("ERROR at %0t: digit_en %b selects no single position", $time, prev_en);
            stop_run();
        end
        changes = 0;
        while (changes < display_pkg::DIGIT_POSITIONS) begin
            @(negedge clk);
            if (digit_en != prev_en) begin
                pos = (pos + 1) % display_pkg::DIGIT_POSITIONS;
                want_en = display_pkg::digit_sel_t'(1) << pos;
                if (pos == display_pkg::DIGIT_POSITIONS - 1) begin
                    want_seg = shown_neg ? display_pkg::SEG_MINUS : display_pkg::SEG_BLANK;
                end else begin
                    want_seg = display_pkg::SEG_TABLE[shown_bcd[pos*4 +: 4]];
                end
                check_seg(sel ? "display of channel b" : "display of channel a",
                          seg, digit_en, want_seg, want_en);
                prev_en = digit_en;
                changes++;
            end
        end
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        int start_a;
        int start_b;
        row = stim_rows[idx];
        @(posedge clk);
        #1;
        start_a = upd_cnt_a;
        start_b = upd_cnt_b;
        value_a = row.value_a;
        value_b = row.value_b;
        display_sel = row.display_sel;
        sample_a = row.mask[0];
        sample_b = row.mask[1];
        @(posedge clk);
        #1;
        sample_a = 1'b0;
        sample_b = 1'b0;
        wait_updates(start_a + int'(row.mask[0]), start_b + int'(row.mask[1]));
        expect_count("channel a update count", upd_cnt_a - start_a, int'(row.mask[0]));
        expect_count("channel b update count", upd_cnt_b - start_b, int'(row.mask[1]));
        @(negedge clk);
        check_bcd("channel a", bcd_a, negative_a, row.exp_bcd_a, row.exp_neg_a);
        check_bcd("channel b", bcd_b, negative_b, row.exp_bcd_b, row.exp_neg_b);
        if (row.mask == 2'b11 && upd_time_a == upd_time_b) begin
            $display("ERROR at %0t: both channels updated in the same cycle", $time);
            stop_run();
        end
        scan_display(row.display_sel,
                     row.display_sel ? row.exp_bcd_b : row.exp_bcd_a,
                     row.display_sel ? row.exp_neg_b : row.exp_neg_a);
    endtask

    // the second strobe lands while the first request is still open.
    task automatic resend_sample(input readout_pkg::bin_t first, input readout_pkg::bin_t second);
        int start_a;
        @(posedge clk);
        #1;
        start_a = upd_cnt_a;
        value_a = first;
        sample_a = 1'b1;
        @(posedge clk);
        #1;
        sample_a = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        value_a = second;
        sample_a = 1'b1;
        @(posedge clk);
        #1;
        sample_a = 1'b0;
        wait_updates(start_a + 2, upd_cnt_b);
        expect_count("channel a updates after a repeated strobe", upd_cnt_a - start_a, 2);
        @(negedge clk);
        check_bcd("channel a after a repeated strobe", bcd_a, negative_a,
                  expected_bcd(second), second[readout_pkg::BIN_WIDTH-1]);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: an update never came within %0d cycles.", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin
        reset = 1'b1;
        sample_a = 1'b0;
        sample_b = 1'b0;
        value_a = '0;
        value_b = '0;
        display_sel = 1'b0;
        lfsr_state = 19'd52;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_bcd("channel a after reset", bcd_a, negative_a, '0, 1'b0);
        check_bcd("channel b after reset", bcd_b, negative_b, '0, 1'b0);
        expect_count("update level after reset", int'(update_a) + int'(update_b), 0);
        check_seg("display after reset", seg, digit_en, display_pkg::SEG_TABLE[0],
                  display_pkg::digit_sel_t'(1));
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        resend_sample(19'h01234, 19'h7fc18); // 4660 and then -1000.
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/readout_pkg.sv
logic/display_pkg.sv
logic/conv_if.sv
logic/bin_to_bcd.sv
logic/conv_arbiter.sv
logic/readout_channel.sv
logic/segment_scanner.sv
logic/readout_top.sv
dv/readout_tb.sv

//--- Makefile
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: obj_dir/Vreadout_tb

obj_dir/Vreadout_tb: sources.f $(SOURCES)
	verilator --binary -f sources.f --top-module readout_tb -o Vreadout_tb

run: obj_dir/Vreadout_tb
	./obj_dir/Vreadout_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
